// ==== verilog/cache_axi_cfg.svh ====
// cache to axi write path configuration
// sizes of the cache side, the axi port and the burst shape
`ifndef CACHE_AXI_CFG_SVH
`define CACHE_AXI_CFG_SVH

// caches sharing the write port
`define NUM_CACHE 2

// cache side
`define DMA_DATA_WIDTH 32
`define BLOCK_WORDS 8
`define TAG_FIFO_ELS `NUM_CACHE

// axi side
`define AXI_ID_WIDTH 4
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64

// one block per burst, so BLOCK_WORDS * DMA_DATA_WIDTH / AXI_DATA_WIDTH
`define AXI_BURST_LEN 4

// cache words per axi beat
`define PACK_RATIO (`AXI_DATA_WIDTH / `DMA_DATA_WIDTH)

`endif

// ==== verilog/axi_pkg.sv ====
// axi field types
// widths of the address and data channels plus burst, size and response codes
`include "cache_axi_cfg.svh"

package axi_pkg;

  typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;
  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [(`AXI_DATA_WIDTH/8)-1:0] axi_strb_t;
  typedef logic [7:0] axi_len_t;

  typedef enum logic [1:0] {
    axi_burst_fixed = 2'b00,
    axi_burst_incr  = 2'b01,
    axi_burst_wrap  = 2'b10
  } axi_burst_e;

  // bytes per beat, log2 coded
  typedef enum logic [2:0] {
    axi_size_1b   = 3'd0,
    axi_size_2b   = 3'd1,
    axi_size_4b   = 3'd2,
    axi_size_8b   = 3'd3,
    axi_size_16b  = 3'd4,
    axi_size_32b  = 3'd5,
    axi_size_64b  = 3'd6,
    axi_size_128b = 3'd7
  } axi_size_e;

  typedef enum logic [1:0] {
    axi_resp_okay   = 2'b00,
    axi_resp_exokay = 2'b01,
    axi_resp_slverr = 2'b10,
    axi_resp_decerr = 2'b11
  } axi_resp_e;

endpackage

// ==== verilog/cache_dma_pkg.sv ====
// cache side types
// tags that pick a cache, dma words and word/beat counters
`include "cache_axi_cfg.svh"

package cache_dma_pkg;

  // at least one bit even with a single cache
  typedef logic [((`NUM_CACHE > 1) ? $clog2(`NUM_CACHE) : 1)-1:0] cache_tag_t;

  typedef logic [`DMA_DATA_WIDTH-1:0] dma_word_t;

  // word index inside a block
  typedef logic [$clog2(`BLOCK_WORDS)-1:0] block_word_cnt_t;

  // beat index inside a burst
  typedef logic [$clog2(`AXI_BURST_LEN)-1:0] beat_cnt_t;

endpackage

// ==== verilog/tag_fifo.sv ====
// tag queue
// keeps the cache tags of issued write bursts in issue order
`timescale 1ns/1ps
`include "cache_axi_cfg.svh"

module tag_fifo
  import cache_dma_pkg::*;
#(
  parameter int els_p = `TAG_FIFO_ELS
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       push_i,
  input  cache_tag_t tag_i,
  output logic       ready_o,
  input  logic       pop_i,
  output logic       v_o,
  output cache_tag_t tag_o
);

  localparam int lg_els_lp = (els_p > 1) ? $clog2(els_p) : 1;

  cache_tag_t mem_q [els_p];
  logic [lg_els_lp-1:0] wr_ptr_q;
  logic [lg_els_lp-1:0] rd_ptr_q;
  logic [$clog2(els_p+1)-1:0] count_q;
  logic push_en;
  logic pop_en;

  assign ready_o = (count_q != els_p);
  assign v_o     = (count_q != 0);
  assign tag_o   = mem_q[rd_ptr_q];

  // guard against overflow and underflow
  assign push_en = push_i & ready_o;
  assign pop_en  = pop_i & v_o;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == lg_els_lp'(els_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == lg_els_lp'(els_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/word_packer.sv ====
// word packer
// gathers PACK_RATIO cache words into one axi data beat, low word first,
// and holds the beat until a drain pulse empties it
`timescale 1ns/1ps
`include "cache_axi_cfg.svh"

module word_packer
  import axi_pkg::*;
  import cache_dma_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      v_i,
  input  dma_word_t word_i,
  output logic      ready_o,
  input  logic      drain_i,
  output logic      full_o,
  output axi_data_t beat_o
);

  localparam int lg_ratio_lp = (`PACK_RATIO > 1) ? $clog2(`PACK_RATIO) : 1;

  dma_word_t slot_q [`PACK_RATIO];
  logic [lg_ratio_lp-1:0] fill_idx_q;
  logic full_q;
  logic wr_en;
  logic last_slot;

  // no room once the beat is complete
  assign ready_o   = ~full_q;
  assign full_o    = full_q;
  assign wr_en     = v_i & ready_o;
  assign last_slot = (fill_idx_q == lg_ratio_lp'(`PACK_RATIO - 1));

  // slot payload
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      slot_q[fill_idx_q] <= word_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_idx_q <= '0;
      full_q     <= 1'b0;
    end else if (drain_i) begin
      fill_idx_q <= '0;
      full_q     <= 1'b0;
    end else if (wr_en) begin
      if (last_slot) begin
        fill_idx_q <= '0;
        full_q     <= 1'b1;
      end else begin
        fill_idx_q <= fill_idx_q + 1'b1;
      end
    end
  end

  // slot 0 lands in the low bits
  always_comb begin
    beat_o = '0;
    for (int i = 0; i < `PACK_RATIO; i++) begin
      beat_o[i*`DMA_DATA_WIDTH +: `DMA_DATA_WIDTH] = slot_q[i];
    end
  end

endmodule

// ==== verilog/cache_to_axi_tx.sv ====
// cache to axi write path
// turns cache eviction requests into axi incr bursts, pulls the block words
// from the cache at the head of the tag queue and packs them into beats
`timescale 1ns/1ps
`include "cache_axi_cfg.svh"

module cache_to_axi_tx
  import axi_pkg::*;
  import cache_dma_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  // eviction request
  input  logic                      v_i,
  input  cache_tag_t                tag_i,
  input  axi_addr_t                 axi_addr_i,
  output logic                      yumi_o,

  // dma data from the caches
  input  dma_word_t [`NUM_CACHE-1:0] dma_data_i,
  input  logic [`NUM_CACHE-1:0]     dma_data_v_i,
  output logic [`NUM_CACHE-1:0]     dma_data_yumi_o,

  // write address channel
  output axi_id_t                   awid_o,
  output axi_addr_t                 awaddr_o,
  output axi_len_t                  awlen_o,
  output axi_size_e                 awsize_o,
  output axi_burst_e                awburst_o,
  output logic [3:0]                awcache_o,
  output logic [2:0]                awprot_o,
  output logic                      awlock_o,
  output logic                      awvalid_o,
  input  logic                      awready_i,

  // write data channel
  output axi_data_t                 wdata_o,
  output axi_strb_t                 wstrb_o,
  output logic                      wlast_o,
  output logic                      wvalid_o,
  input  logic                      wready_i,

  // write response channel, accepted and dropped
  input  axi_id_t                   bid_i,
  input  axi_resp_e                 bresp_i,
  input  logic                      bvalid_i,
  output logic                      bready_o
);

  logic tag_ready;
  logic tag_v;
  logic tag_pop;
  cache_tag_t head_tag;

  logic pack_ready;
  logic pack_full;
  logic pack_drain;
  logic word_take;
  logic [`NUM_CACHE-1:0] cache_sel;

  block_word_cnt_t word_cnt_q;
  beat_cnt_t beat_cnt_q;
  logic last_word;
  logic beat_accept;

  // address channel
  assign awvalid_o = v_i & tag_ready;
  assign yumi_o    = awvalid_o & awready_i;

  assign awid_o    = '0;
  assign awaddr_o  = axi_addr_i;
  assign awlen_o   = axi_len_t'(`AXI_BURST_LEN - 1);
  assign awsize_o  = axi_size_e'($clog2(`AXI_DATA_WIDTH / 8));
  assign awburst_o = axi_burst_incr;
  // normal, unprivileged, non-cacheable
  assign awcache_o = 4'b0000;
  assign awprot_o  = 3'b000;
  assign awlock_o  = 1'b0;

  tag_fifo #(
    .els_p(`TAG_FIFO_ELS)
  ) tag_queue (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (yumi_o),
    .tag_i  (tag_i),
    .ready_o(tag_ready),
    .pop_i  (tag_pop),
    .v_o    (tag_v),
    .tag_o  (head_tag)
  );

  // only the cache at the queue head may hand over words
  always_comb begin
    cache_sel = '0;
    if (tag_v) begin
      cache_sel[head_tag] = 1'b1;
    end
  end

  assign dma_data_yumi_o = cache_sel & dma_data_v_i & {`NUM_CACHE{pack_ready}};
  assign word_take       = |dma_data_yumi_o;

  word_packer packer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (word_take),
    .word_i (dma_data_i[head_tag]),
    .ready_o(pack_ready),
    .drain_i(pack_drain),
    .full_o (pack_full),
    .beat_o (wdata_o)
  );

  // data channel
  assign wvalid_o    = pack_full;
  assign wstrb_o     = '1;
  assign beat_accept = wvalid_o & wready_i;
  assign pack_drain  = beat_accept;
  assign wlast_o     = wvalid_o & (beat_cnt_q == beat_cnt_t'(`AXI_BURST_LEN - 1));

  // block ends on its last word, so the head tag goes in the same cycle
  assign last_word = (word_cnt_q == block_word_cnt_t'(`BLOCK_WORDS - 1));
  assign tag_pop   = word_take & last_word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      word_cnt_q <= '0;
    end else if (word_take) begin
      word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
    end
  end

  // beats accepted within the current burst
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_cnt_q <= '0;
    end else if (beat_accept) begin
      beat_cnt_q <= wlast_o ? '0 : beat_cnt_q + 1'b1;
    end
  end

  // responses are not tracked, bid_i, bresp_i and bvalid_i are just sunk
  assign bready_o = 1'b1;

endmodule

// ==== sim/cache_to_axi_tx_tb.sv ====
// testbench for the cache to axi write path
// cache models feed dma words, an axi slave model collects aw and w transfers
`timescale 1ns/1ps
`include "cache_axi_cfg.svh"

module cache_to_axi_tx_tb
  import axi_pkg::*;
  import cache_dma_pkg::*;
;

  localparam int clk_period_lp = 10;
  localparam int num_tests_lp  = 5;

  logic clk;
  logic reset;
  logic v;
  cache_tag_t tag;
  axi_addr_t addr;
  logic yumi;
  dma_word_t [`NUM_CACHE-1:0] dma_data = '0;
  logic [`NUM_CACHE-1:0] dma_v = '0;
  logic [`NUM_CACHE-1:0] dma_yumi;
  axi_id_t awid;
  axi_addr_t awaddr;
  axi_len_t awlen;
  axi_size_e awsize;
  axi_burst_e awburst;
  logic [3:0] awcache;
  logic [2:0] awprot;
  logic awlock;
  logic awvalid;
  logic awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic wlast;
  logic wvalid;
  logic wready = 1'b1;
  axi_id_t bid;
  axi_resp_e bresp;
  logic bvalid;
  logic bready;

  integer seed = 32'hd58a;
  int errors = 0;
  logic rand_wready = 1'b0;
  logic [`NUM_CACHE-1:0] dma_en = '1;
  int taken_cnt [`NUM_CACHE];

  // cache model contents and slave model captures
  dma_word_t cache_q [`NUM_CACHE][$];
  axi_data_t exp_beats[$];
  axi_data_t got_beats[$];
  logic got_last[$];
  axi_addr_t exp_addr[$];
  axi_addr_t got_addr[$];

  cache_to_axi_tx uut (
    .clk_i(clk), .reset_i(reset),
    .v_i(v), .tag_i(tag), .axi_addr_i(addr), .yumi_o(yumi),
    .dma_data_i(dma_data), .dma_data_v_i(dma_v), .dma_data_yumi_o(dma_yumi),
    .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
    .awburst_o(awburst), .awcache_o(awcache), .awprot_o(awprot), .awlock_o(awlock),
    .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wvalid_o(wvalid),
    .wready_i(wready),
    .bid_i(bid), .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  task automatic check_addr(string name, axi_addr_t got, axi_addr_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(string name, axi_data_t got, axi_data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_len(string name, axi_len_t got, axi_len_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_burst(string name, axi_burst_e got, axi_burst_e exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_size(string name, axi_size_e got, axi_size_e exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(string name, axi_id_t got, axi_id_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_strb(string name, axi_strb_t got, axi_strb_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // cache and prot attribute fields
  task automatic check_attr(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // sample handshakes at the edge, then drive the caches and wready
  always @(posedge clk) begin
    if (!reset) begin
      for (int c = 0; c < `NUM_CACHE; c++) begin
        if (dma_yumi[c] && (cache_q[c].size() == 0 || !dma_v[c])) begin
          $display("dma yumi given to cache %0d while it offered no word", c);
          errors++;
        end else if (dma_yumi[c]) begin
          void'(cache_q[c].pop_front());
          taken_cnt[c]++;
        end
      end
      if (awvalid && awready) begin
        got_addr.push_back(awaddr);
        check_len("awlen_o", awlen, 8'd3);
        check_size("awsize_o", awsize, axi_size_8b);
        check_burst("awburst_o", awburst, axi_burst_incr);
        check_id("awid_o", awid, '0);
        check_attr("awcache_o", awcache, 4'b0000);
        check_attr("awprot_o", {1'b0, awprot}, 4'b0000);
        check_bit("awlock_o", awlock, 1'b0);
      end
      if (wvalid && wready) begin
        got_beats.push_back(wdata);
        got_last.push_back(wlast);
        check_strb("wstrb_o", wstrb, '1);
      end
    end
    #1;
    for (int c = 0; c < `NUM_CACHE; c++) begin
      dma_v[c] = dma_en[c] && (cache_q[c].size() != 0);
      dma_data[c] = (cache_q[c].size() != 0) ? cache_q[c][0] : '0;
    end
    wready = rand_wready ? (($random(seed) & 1) != 0) : 1'b1;
  end

  // word i of block blk in cache c
  function automatic dma_word_t block_word(int c, int blk, int i);
    return {8'hca, 8'(c), 8'(blk), 8'(i)};
  endfunction

  task automatic load_block(int c, int blk);
    for (int i = 0; i < `BLOCK_WORDS; i++) begin
      cache_q[c].push_back(block_word(c, blk, i));
    end
  endtask

  // low word of each beat comes first from the cache
  task automatic expect_block(int c, int blk);
    axi_data_t beat;
    for (int k = 0; k < `AXI_BURST_LEN; k++) begin
      for (int j = 0; j < `PACK_RATIO; j++) begin
        beat[j*`DMA_DATA_WIDTH +: `DMA_DATA_WIDTH] = block_word(c, blk, k*`PACK_RATIO + j);
      end
      exp_beats.push_back(beat);
    end
  endtask

  task automatic send_req(cache_tag_t t, axi_addr_t a);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    v = 1'b1;
    tag = t;
    addr = a;
    exp_addr.push_back(a);
    @(negedge clk);
    while (!yumi && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!yumi) begin
      $display("request for cache %0d was never accepted", t);
      errors++;
    end
    @(posedge clk);
    #1;
    v = 1'b0;
  endtask

  // wait for all expected beats, then compare beats and addresses in order
  task automatic compare_all();
    int cycles;
    int idx;
    cycles = 0;
    idx = 0;
    while (got_beats.size() < exp_beats.size() && cycles < 300) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk);
    if (got_beats.size() != exp_beats.size()) begin
      $display("got %0d write beats, expected %0d", got_beats.size(), exp_beats.size());
      errors++;
    end
    if (got_addr.size() != exp_addr.size()) begin
      $display("got %0d address transfers, expected %0d", got_addr.size(), exp_addr.size());
      errors++;
    end
    while (exp_beats.size() != 0 && got_beats.size() != 0) begin
      check_beat("wdata_o", got_beats.pop_front(), exp_beats.pop_front());
      check_bit("wlast_o", got_last.pop_front(), (idx % `AXI_BURST_LEN) == `AXI_BURST_LEN - 1);
      idx++;
    end
    while (exp_addr.size() != 0 && got_addr.size() != 0) begin
      check_addr("awaddr_o", got_addr.pop_front(), exp_addr.pop_front());
    end
    exp_beats.delete();
    got_beats.delete();
    got_last.delete();
    exp_addr.delete();
    got_addr.delete();
  endtask

  task automatic test_single_block();
    load_block(0, 1);
    expect_block(0, 1);
    send_req(0, 32'h0000_1000);
    compare_all();
  endtask

  // cache 0 offers words while cache 1 owns the queue head
  task automatic test_cache_select();
    load_block(0, 2);
    load_block(1, 2);
    expect_block(1, 2);
    send_req(1, 32'h0000_2040);
    compare_all();
    if (cache_q[0].size() != `BLOCK_WORDS) begin
      $display("cache 0 lost words while cache 1 was at the queue head");
      errors++;
    end
    cache_q[0].delete();
  endtask

  task automatic test_addr_backpressure();
    load_block(0, 3);
    expect_block(0, 3);
    @(posedge clk);
    #1;
    awready = 1'b0;
    v = 1'b1;
    tag = 0;
    addr = 32'h0000_3080;
    exp_addr.push_back(32'h0000_3080);
    repeat (3) begin
      @(negedge clk);
      check_bit("awvalid_o", awvalid, 1'b1);
      check_bit("yumi_o", yumi, 1'b0);
    end
    @(posedge clk);
    #1;
    awready = 1'b1;
    @(negedge clk);
    check_bit("yumi_o", yumi, 1'b1);
    @(posedge clk);
    #1;
    v = 1'b0;
    compare_all();
  endtask

  task automatic test_data_backpressure();
    rand_wready = 1'b1;
    load_block(0, 4);
    load_block(1, 4);
    expect_block(0, 4);
    expect_block(1, 4);
    send_req(0, 32'h0000_4000);
    send_req(1, 32'h0000_4100);
    compare_all();
    rand_wready = 1'b0;
  endtask

  // queue holds two tags, a third waits until the first block drains
  task automatic test_queue_order();
    int start;
    int cycles;
    cycles = 0;
    dma_en = '0;
    start = taken_cnt[1];
    load_block(1, 5);
    load_block(0, 5);
    load_block(1, 6);
    expect_block(1, 5);
    expect_block(0, 5);
    expect_block(1, 6);
    send_req(1, 32'h0000_5000);
    send_req(0, 32'h0000_5100);
    @(posedge clk);
    #1;
    v = 1'b1;
    tag = 1;
    addr = 32'h0000_5200;
    exp_addr.push_back(32'h0000_5200);
    @(negedge clk);
    check_bit("awvalid_o", awvalid, 1'b0);
    @(posedge clk);
    dma_en = '1;
    @(negedge clk);
    while (!yumi && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!yumi) begin
      $display("third request was never accepted");
      errors++;
    end else if (taken_cnt[1] - start < `BLOCK_WORDS) begin
      $display("third request accepted before the first block was drained");
      errors++;
    end
    @(posedge clk);
    #1;
    v = 1'b0;
    compare_all();
  endtask

  initial begin
    #(num_tests_lp * 400 * clk_period_lp);
    $display("watchdog timeout, tests did not finish, errors so far: %0d", errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    v = 1'b0;
    tag = '0;
    addr = '0;
    awready = 1'b1;
    bid = '0;
    bresp = axi_resp_okay;
    bvalid = 1'b0;
    for (int c = 0; c < `NUM_CACHE; c++) begin
      taken_cnt[c] = 0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_bit("wvalid_o", wvalid, 1'b0);
    check_bit("bready_o", bready, 1'b1);
    test_single_block();
    test_cache_select();
    test_addr_backpressure();
    test_data_backpressure();
    test_queue_order();
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/cache_dma_pkg.sv
verilog/tag_fifo.sv
verilog/word_packer.sv
verilog/cache_to_axi_tx.sv
sim/cache_to_axi_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cache to axi write path testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f \
  --top-module cache_to_axi_tx_tb -o cache_to_axi_tx_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/cache_to_axi_tx_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
